// File: verilog/zx_bus_pkg.sv
package zx_bus_pkg;

  // cpu i/o bus as seen by the sound block
  // all strobes active high here
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        iorq;
    logic        wr;
    logic        rd;
  } io_bus_t;

  // port groups known to the decoder
  typedef enum logic [2:0] {
    PORT_NONE     = 3'd0,
    PORT_FE       = 3'd1,
    PORT_COVOX    = 3'd2,
    PORT_PSG_ADDR = 3'd3,
    PORT_PSG_DATA = 3'd4
  } port_kind_e;

  // one decoded write, valid for a single clock
  typedef struct packed {
    logic       valid;
    port_kind_e kind;
    logic [7:0] data;
  } io_cmd_t;

  // ula port, border / tape out / beeper
  localparam logic [7:0] FE_LOW = 8'hFE;

  // covox dac
  localparam logic [7:0] COVOX_LOW = 8'hFB;

  // ay / turbosound, #FFFD selects and #BFFD writes data
  // only a15, a14 and the low nibble take part
  localparam logic [3:0] PSG_LOW_NIBBLE = 4'hD;

endpackage

// File: verilog/zx_audio_pkg.sv
package zx_audio_pkg;

  // stereo placement of the three psg channels
  typedef enum logic [1:0] {
    MIX_ABC   = 2'd0,
    MIX_ACB   = 2'd1,
    MIX_MONO  = 2'd2,
    MIX_MONO2 = 2'd3
  } mix_mode_e;

  // everything the mixer needs from the port registers
  typedef struct packed {
    logic       speaker;
    logic       tape_out;
    logic [7:0] covox;
    logic [3:0] vol_a;
    logic [3:0] vol_b;
    logic [3:0] vol_c;
  } sound_levels_t;

  // beeper contribution when the speaker bit is set
  localparam logic [15:0] SPEAKER_LEVEL = 16'h1000;

  // tape input monitor, half the beeper
  localparam logic [15:0] TAPE_IN_LEVEL = 16'h0800;

  // volume nibble weight, value times 256
  localparam int PSG_SHIFT = 8;

  // covox byte weight
  localparam int COVOX_SHIFT = 4;

endpackage

// File: verilog/io_decode.sv
`timescale 1ns/1ps

module io_decode
  import zx_bus_pkg::*;
(
  input  logic       clk_28mhz,
  input  logic       rst,
  input  io_bus_t    bus,
  output io_cmd_t    cmd,
  output port_kind_e rd_kind
);

  io_bus_t    bus_q;
  logic       iowr_q;
  logic       iowr_prev;
  port_kind_e wr_kind;

  // address to port group, low byte first, then the psg pair
  function automatic port_kind_e classify(input logic [15:0] addr);
    port_kind_e kind;
    kind = PORT_NONE;
    if (addr[7:0] == FE_LOW) begin
      kind = PORT_FE;
    end else if (addr[7:0] == COVOX_LOW) begin
      kind = PORT_COVOX;
    end else if (addr[15] && (addr[3:0] == PSG_LOW_NIBBLE)) begin
      kind = addr[14] ? PORT_PSG_ADDR : PORT_PSG_DATA;
    end
    return kind;
  endfunction

  // bus sampled every clock
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      bus_q     <= '0;
      iowr_prev <= 1'b0;
    end else begin
      bus_q     <= bus;
      iowr_prev <= iowr_q;
    end
  end

  assign iowr_q  = bus_q.iorq & bus_q.wr;
  assign wr_kind = classify(bus_q.addr);

  // rising edge of iorq&wr gives one command, however long the write
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      cmd <= '0;
    end else begin
      cmd.valid <= iowr_q & ~iowr_prev & (wr_kind != PORT_NONE);
      cmd.kind  <= wr_kind;
      cmd.data  <= bus_q.wdata;
    end
  end

  // reads decode straight off the live bus
  assign rd_kind = (bus.iorq && bus.rd) ? classify(bus.addr) : PORT_NONE;

  a_one_cmd_per_write: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    cmd.valid |=> !cmd.valid
  ) else $error("io_decode: write command held for two cycles");

endmodule

// File: verilog/port_regs.sv
`timescale 1ns/1ps

module port_regs
  import zx_bus_pkg::*, zx_audio_pkg::*;
(
  input  logic          clk_28mhz,
  input  logic          rst,
  input  io_cmd_t       cmd,
  input  port_kind_e    rd_kind,
  input  logic          tape_in,
  output logic [7:0]    cpu_rdata,
  output logic [2:0]    border,
  output sound_levels_t levels
);

  // psg register numbers of the channel volumes
  localparam logic [3:0] REG_VOL_A = 4'd8;
  localparam logic [3:0] REG_VOL_B = 4'd9;
  localparam logic [3:0] REG_VOL_C = 4'd10;

  // #FE bits 4..0, speaker / tape out / border
  logic [4:0] fe_q;
  logic [7:0] covox_q;
  logic [3:0] psg_sel_q;
  logic [3:0] vol_a_q;
  logic [3:0] vol_b_q;
  logic [3:0] vol_c_q;
  logic [3:0] sel_vol;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_q      <= '0;
      covox_q   <= '0;
      psg_sel_q <= '0;
      vol_a_q   <= '0;
      vol_b_q   <= '0;
      vol_c_q   <= '0;
    end else if (cmd.valid) begin
      case (cmd.kind)
        PORT_FE: fe_q <= cmd.data[4:0];
        PORT_COVOX: covox_q <= cmd.data;
        PORT_PSG_ADDR: psg_sel_q <= cmd.data[3:0];
        PORT_PSG_DATA: begin
          // tone, noise and envelope registers are not kept
          case (psg_sel_q)
            REG_VOL_A: vol_a_q <= cmd.data[3:0];
            REG_VOL_B: vol_b_q <= cmd.data[3:0];
            REG_VOL_C: vol_c_q <= cmd.data[3:0];
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // readback of the selected psg register
  always_comb begin
    case (psg_sel_q)
      REG_VOL_A: sel_vol = vol_a_q;
      REG_VOL_B: sel_vol = vol_b_q;
      REG_VOL_C: sel_vol = vol_c_q;
      default:   sel_vol = 4'h0;
    endcase
  end

  // #FE read shows the ear input on bit 6, keyboard lines idle high
  always_comb begin
    case (rd_kind)
      PORT_PSG_ADDR: cpu_rdata = {4'h0, sel_vol};
      PORT_FE:       cpu_rdata = {1'b1, tape_in, 1'b1, 5'b11111};
      default:       cpu_rdata = 8'hFF;
    endcase
  end

  assign border          = fe_q[2:0];
  assign levels.tape_out = fe_q[3];
  assign levels.speaker  = fe_q[4];
  assign levels.covox    = covox_q;
  assign levels.vol_a    = vol_a_q;
  assign levels.vol_b    = vol_b_q;
  assign levels.vol_c    = vol_c_q;

  a_cmd_has_port: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    cmd.valid |-> (cmd.kind != PORT_NONE)
  ) else $error("port_regs: valid command without a port");

endmodule

// File: verilog/sample_clock.sv
`timescale 1ns/1ps

module sample_clock #(
  parameter int CE_DIV = 8
) (
  input  logic clk_28mhz,
  input  logic rst,
  output logic sample_ce
);

  localparam int CNT_W = $clog2(CE_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CE_DIV - 1);

  logic [CNT_W-1:0] cnt;

  // one pulse per wrap, 28 MHz / 8 gives 3.5 MHz
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      cnt       <= '0;
      sample_ce <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt       <= '0;
      sample_ce <= 1'b1;
    end else begin
      cnt       <= cnt + 1'b1;
      sample_ce <= 1'b0;
    end
  end

  a_ce_single: assert property (
    @(posedge clk_28mhz) disable iff (rst)
    sample_ce |=> !sample_ce
  ) else $error("sample_clock: enable high on consecutive clocks");

endmodule

// File: verilog/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer
  import zx_audio_pkg::*;
(
  input  logic          clk_28mhz,
  input  logic          rst,
  input  logic          sample_ce,
  input  sound_levels_t levels,
  input  logic          tape_in,
  input  mix_mode_e     mix_mode,
  output logic [15:0]   audio_l,
  output logic [15:0]   audio_r
);

  logic [15:0] lvl_a;
  logic [15:0] lvl_b;
  logic [15:0] lvl_c;
  logic [15:0] lvl_covox;
  logic [15:0] common;
  logic [15:0] psg_l;
  logic [15:0] psg_r;

  // volumes act as dc levels with no tone generators behind them
  assign lvl_a     = 16'(levels.vol_a) << PSG_SHIFT;
  assign lvl_b     = 16'(levels.vol_b) << PSG_SHIFT;
  assign lvl_c     = 16'(levels.vol_c) << PSG_SHIFT;
  assign lvl_covox = 16'(levels.covox) << COVOX_SHIFT;

  // sources shared by both sides
  assign common = (levels.speaker ? SPEAKER_LEVEL : 16'h0000)
                + (tape_in ? TAPE_IN_LEVEL : 16'h0000)
                + lvl_covox;

  always_comb begin
    case (mix_mode)
      MIX_ABC: begin
        psg_l = lvl_a + lvl_b;
        psg_r = lvl_b + lvl_c;
      end
      MIX_ACB: begin
        psg_l = lvl_a + lvl_c;
        psg_r = lvl_c + lvl_b;
      end
      // both mono settings sum all three channels
      default: begin
        psg_l = lvl_a + lvl_b + lvl_c;
        psg_r = lvl_a + lvl_b + lvl_c;
      end
    endcase
  end

  // worst case sum is 21744 so no clipping is needed
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_l <= '0;
      audio_r <= '0;
    end else if (sample_ce) begin
      audio_l <= common + psg_l;
      audio_r <= common + psg_r;
    end
  end

endmodule

// File: verilog/zx_sound_io.sv
`timescale 1ns/1ps

module zx_sound_io
  import zx_bus_pkg::*, zx_audio_pkg::*;
#(
  parameter int CE_DIV = 8
) (
  input  logic        clk_28mhz,
  input  logic        rst,
  input  io_bus_t     bus,
  input  logic        tape_in,
  input  logic [1:0]  mix_mode,
  output logic [7:0]  cpu_rdata,
  output logic [2:0]  border,
  output logic        tape_out,
  output logic        beep,
  output logic [15:0] audio_l,
  output logic [15:0] audio_r
);

  io_cmd_t       cmd;
  port_kind_e    rd_kind;
  sound_levels_t levels;
  logic          sample_ce;

  io_decode u_io_decode (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .bus       (bus),
    .cmd       (cmd),
    .rd_kind   (rd_kind)
  );

  port_regs u_port_regs (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .cmd       (cmd),
    .rd_kind   (rd_kind),
    .tape_in   (tape_in),
    .cpu_rdata (cpu_rdata),
    .border    (border),
    .levels    (levels)
  );

  sample_clock #(
    .CE_DIV (CE_DIV)
  ) u_sample_clock (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .sample_ce (sample_ce)
  );

  audio_mixer u_audio_mixer (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .sample_ce (sample_ce),
    .levels    (levels),
    .tape_in   (tape_in),
    .mix_mode  (mix_mode_e'(mix_mode)),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

  // beeper pin follows the speaker bit
  assign tape_out = levels.tape_out;
  assign beep     = levels.speaker;

endmodule

// File: verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr with taps 32 22 2 1
logic [31:0] lfsr_q = 32'h5b3229f3;

// expected port register contents
logic [4:0] m_fe = '0;
logic [7:0] m_covox = '0;
logic [3:0] m_sel = '0;
logic [3:0] m_vol_a = '0;
logic [3:0] m_vol_b = '0;
logic [3:0] m_vol_c = '0;

// one lfsr step per bit taken, newest bit ends up in bit 0
function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] r;
  logic        fb;
  int          k;
  r = '0;
  for (k = 0; k < n; k++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    r      = {r[14:0], fb};
  end
  return r;
endfunction

// low byte decides first, then a15/a14 with the D nibble
function automatic port_kind_e port_of(input logic [15:0] addr);
  if (addr[7:0] == 8'hFE) begin
    return PORT_FE;
  end else if (addr[7:0] == 8'hFB) begin
    return PORT_COVOX;
  end else if (addr[15] && (addr[3:0] == 4'hD)) begin
    return addr[14] ? PORT_PSG_ADDR : PORT_PSG_DATA;
  end
  return PORT_NONE;
endfunction

function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
  case (port_of(addr))
    PORT_FE:       m_fe = data[4:0];
    PORT_COVOX:    m_covox = data;
    PORT_PSG_ADDR: m_sel = data[3:0];
    PORT_PSG_DATA: begin
      if (m_sel == 4'd8) m_vol_a = data[3:0];
      if (m_sel == 4'd9) m_vol_b = data[3:0];
      if (m_sel == 4'd10) m_vol_c = data[3:0];
    end
    default: ;
  endcase
endfunction

function automatic logic [7:0] exp_read(input logic [15:0] addr, input logic tape);
  case (port_of(addr))
    PORT_FE: return {1'b1, tape, 6'b111111};
    PORT_PSG_ADDR: begin
      if (m_sel == 4'd8) return {4'h0, m_vol_a};
      if (m_sel == 4'd9) return {4'h0, m_vol_b};
      if (m_sel == 4'd10) return {4'h0, m_vol_c};
      return 8'h00;
    end
    default: return 8'hFF;
  endcase
endfunction

// speaker, tape and covox go to both sides, psg channels placed by mode
function automatic logic [15:0] exp_audio(input logic right, input logic tape,
                                          input logic [1:0] mode);
  int a;
  int b;
  int c;
  int sum;
  a   = int'(m_vol_a) * 256;
  b   = int'(m_vol_b) * 256;
  c   = int'(m_vol_c) * 256;
  sum = (m_fe[4] ? 4096 : 0) + (tape ? 2048 : 0) + int'(m_covox) * 16;
  case (mode)
    2'd0:    sum += right ? b + c : a + b;
    2'd1:    sum += right ? c + b : a + c;
    default: sum += a + b + c;
  endcase
  return 16'(sum);
endfunction

`endif

// File: verification/tb_zx_sound_io.sv
`timescale 1ns/1ps

module tb_zx_sound_io
  import zx_bus_pkg::*;
();

  localparam int CE_DIV = 8;

  logic        clk_28mhz;
  logic        rst;
  io_bus_t     bus;
  logic        tape_in;
  logic [1:0]  mix_mode;
  logic [7:0]  cpu_rdata;
  logic [2:0]  border;
  logic        tape_out;
  logic        beep;
  logic [15:0] audio_l;
  logic [15:0] audio_r;
  int          value_errors = 0;
  int          timeout_errors = 0;
  logic [15:0] a;
  logic [3:0]  sel;
  int          i;
  int          j;

  `include "tb_model.svh"

  zx_sound_io #(.CE_DIV(CE_DIV)) u_dut (.*);

  initial begin
    clk_28mhz = 1'b0;
    forever #20 clk_28mhz = ~clk_28mhz;
  end

  task automatic check_value(input logic [15:0] got, input logic [15:0] want,
                             input string what);
    assert (got === want) else begin
      value_errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_regs();
    check_value(16'(border), 16'(m_fe[2:0]), "border");
    check_value(16'(tape_out), 16'(m_fe[3]), "tape_out");
    check_value(16'(beep), 16'(m_fe[4]), "beep");
  endtask

  // two clocks of write and one idle clock with registers due on the third edge
  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    bus.addr  = addr;
    bus.wdata = data;
    {bus.iorq, bus.wr, bus.rd} = 3'b110;
    repeat (2) @(negedge clk_28mhz);
    {bus.iorq, bus.wr, bus.rd} = 3'b000;
    @(negedge clk_28mhz);
    model_write(addr, data);
    check_regs();
  endtask

  task automatic check_read(input logic [15:0] addr, input string what);
    bus.addr = addr;
    {bus.iorq, bus.wr, bus.rd} = 3'b101;
    @(negedge clk_28mhz);
    check_value(16'(cpu_rdata), 16'(exp_read(addr, tape_in)), what);
    {bus.iorq, bus.wr, bus.rd} = 3'b000;
    @(negedge clk_28mhz);
  endtask

  // new levels reach the outputs on the next sample enable
  task automatic wait_audio();
    logic [15:0] want_l;
    logic [15:0] want_r;
    int          n;
    want_l = exp_audio(1'b0, tape_in, mix_mode);
    want_r = exp_audio(1'b1, tape_in, mix_mode);
    for (n = 0; n < CE_DIV + 6 && (audio_l !== want_l || audio_r !== want_r); n++) begin
      @(negedge clk_28mhz);
    end
    if (audio_l !== want_l || audio_r !== want_r) begin
      timeout_errors++;
      $display("timeout: audio outputs did not settle within %0d clocks", CE_DIV + 6);
    end
    check_value(audio_l, want_l, "audio_l");
    check_value(audio_r, want_r, "audio_r");
  endtask

  initial begin
    rst      = 1'b1;
    bus      = '0;
    tape_in  = 1'b0;
    mix_mode = 2'd0;
    repeat (16) @(negedge clk_28mhz);
    rst = 1'b0;

    // state right after reset with the bus idle
    check_regs();
    check_value(audio_l, 16'h0000, "audio_l after reset");
    check_value(audio_r, 16'h0000, "audio_r after reset");
    check_value(16'(cpu_rdata), 16'h00FF, "idle read data");

    // random #FE writes each followed by an FE read
    for (i = 0; i < 12; i++) begin
      io_write({8'(rand_bits(8)), 8'hFE}, 8'(rand_bits(8)));
      tape_in = 1'(rand_bits(1));
      check_read({8'(rand_bits(8)), 8'hFE}, "fe read");
    end

    // psg select then data where only registers 8 to 10 keep anything
    for (i = 0; i < 16; i++) begin
      sel = (i < 9) ? 4'(8 + i % 3) : 4'(rand_bits(4));
      io_write({2'b11, 10'(rand_bits(10)), 4'hD}, {4'(rand_bits(4)), sel});
      io_write({2'b10, 10'(rand_bits(10)), 4'hD}, 8'(rand_bits(8)));
      check_read(16'hFFFD, "psg register read");
    end
    for (i = 8; i < 11; i++) begin
      io_write(16'hFFFD, 8'(i));
      check_read(16'hFFFD, "psg volume readback");
    end

    // random levels with each mix mode twice
    for (i = 0; i < 8; i++) begin
      mix_mode = 2'(i / 2);
      tape_in  = 1'(rand_bits(1));
      io_write({8'(rand_bits(8)), 8'hFB}, 8'(rand_bits(8)));
      io_write(16'hFEFE, 8'(rand_bits(8)));
      for (j = 8; j < 11; j++) begin
        io_write(16'hFFFD, 8'(j));
        io_write(16'hBFFD, 8'(rand_bits(8)));
      end
      wait_audio();
    end

    // long write with data flipped halfway so only the first value may land
    a         = 16'(rand_bits(8));
    bus.addr  = 16'h7FFE;
    bus.wdata = 8'(a);
    {bus.iorq, bus.wr, bus.rd} = 3'b110;
    repeat (3) @(negedge clk_28mhz);
    bus.wdata = ~bus.wdata;
    repeat (3) @(negedge clk_28mhz);
    {bus.iorq, bus.wr, bus.rd} = 3'b000;
    @(negedge clk_28mhz);
    model_write(16'h7FFE, 8'(a));
    check_regs();

    // undecoded addresses
    for (i = 0; i < 10; i++) begin
      a = rand_bits(16);
      for (j = 0; j < 20 && port_of(a) != PORT_NONE; j++) begin
        a = rand_bits(16);
      end
      io_write(a, 8'(rand_bits(8)));
      check_read(a, "undecoded read");
    end
    check_read(16'hFFFD, "psg select after undecoded writes");
    wait_audio();

    $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: zx_sound_io.f
+incdir+verification
verilog/zx_bus_pkg.sv
verilog/zx_audio_pkg.sv
verilog/io_decode.sv
verilog/port_regs.sv
verilog/sample_clock.sv
verilog/audio_mixer.sv
verilog/zx_sound_io.sv
verification/tb_zx_sound_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
  --top-module tb_zx_sound_io -f zx_sound_io.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
